// ==== Makefile ====
# Verilator build and run for the enable generator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= enable_gen_tb
FILELIST  ?= enable_gen_top.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_TEXT := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/enable_gen_checker.sv ====
// ======================================================================
// Enable generator checker
// Bus response and enable pulse assertions, bound into the top level
// ======================================================================
`timescale 1ns/1ps

module enable_gen_checker (
    input logic                        clock,
    input logic                        reset,
    input enable_gen_pkg::bus_req_t    bus_req,
    input enable_gen_pkg::bus_rsp_t    bus_rsp,
    input enable_gen_pkg::gen_config_t gen_config,
    input enable_gen_pkg::enable_vec_t enable_out
);
    logic write_accepted;

    // A strobe only counts while the slave is ready
    assign write_accepted = bus_req.write_strobe & bus_rsp.ready;

    read_valid_single: assert property (@(posedge clock) disable iff (!reset)
        bus_rsp.read_valid |=> !bus_rsp.read_valid)
        else $error("read_valid high for two cycles");

    read_data_idle: assert property (@(posedge clock) disable iff (!reset)
        !bus_rsp.read_valid |-> bus_rsp.read_data == '0)
        else $error("read_data nonzero without read_valid");

    busy_after_write: assert property (@(posedge clock) disable iff (!reset)
        ($past(write_accepted) || $past(write_accepted, 2)) |-> !bus_rsp.ready)
        else $error("ready high within two cycles of an accepted write");

    pulse_single: assert property (@(posedge clock) disable iff (!reset)
        gen_config.period != '0 |-> (enable_out & $past(enable_out)) == '0)
        else $error("enable bit high on two consecutive cycles");

endmodule

bind enable_gen_top enable_gen_checker enable_gen_checker_inst (
    .clock      (clock),
    .reset      (reset),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .gen_config (gen_config),
    .enable_out (enable_out)
);

// ==== bench/enable_gen_tb.sv ====
// ======================================================================
// Enable generator testbench
// Table-driven register setup and readback over the strobe bus,
// pulse spacing, channel phase and restart checks
// ======================================================================
`timescale 1ns/1ps

module enable_gen_tb;
    import enable_gen_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int REG_COUNT    = 2 + CHANNEL_COUNT;
    localparam int ROW_COUNT    = 4;
    localparam int WAIT_LIMIT   = 64;

    // One channel setup per table row
    typedef struct packed {
        count_t                     period;
        count_t [CHANNEL_COUNT-1:0] threshold;
        logic                       use_run;
    } row_t;

    logic        clock;
    logic        reset;
    logic        gen_enable_in;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    enable_vec_t enable_out;

    row_t      table_rows [ROW_COUNT];
    bus_data_t model_regs [REG_COUNT];
    integer    seed;
    int        data_errors;
    int        enable_errors;
    int        count_errors;
    int        timeout_errors;
    count_t    cycle_count;
    int        pulse_total [CHANNEL_COUNT];
    count_t    first_pulse [CHANNEL_COUNT];
    count_t    last_pulse  [CHANNEL_COUNT];
    count_t    gap_min     [CHANNEL_COUNT];
    count_t    gap_max     [CHANNEL_COUNT];

    enable_gen_top enable_gen_top_inst (
        .clock         (clock),
        .reset         (reset),
        .gen_enable_in (gen_enable_in),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .enable_out    (enable_out)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // The level logged at edge k was set by edge k-1
    always @(posedge clock) begin
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            if (enable_out[n]) begin
                if (pulse_total[n] == 0) begin
                    first_pulse[n] = cycle_count;
                end else begin
                    gap_min[n] = (cycle_count - last_pulse[n] < gap_min[n]) ?
                                 cycle_count - last_pulse[n] : gap_min[n];
                    gap_max[n] = (cycle_count - last_pulse[n] > gap_max[n]) ?
                                 cycle_count - last_pulse[n] : gap_max[n];
                end
                last_pulse[n] = cycle_count;
                pulse_total[n]++;
            end
        end
        cycle_count++;
    end

    task automatic check_data(input bus_data_t actual, input bus_data_t expected,
                              input string what);
        if (actual !== expected) begin
            data_errors++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_enable(input enable_vec_t actual, input enable_vec_t expected,
                                input string what);
        if (actual !== expected) begin
            enable_errors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input count_t actual, input count_t expected,
                               input string what);
        if (actual !== expected) begin
            count_errors++;
            $display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (bus_rsp.ready !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (bus_rsp.ready !== 1'b1) begin
            timeout_errors++;
            $display("Timed out waiting for the bus to become ready");
        end
    endtask

    task automatic bus_write(input bus_addr_t address, input bus_data_t data);
        bus_addr_t offset;
        int        low_cycles;
        wait_ready();
        bus_req.address      = address;
        bus_req.write_data   = data;
        bus_req.write_strobe = 1'b1;
        @(negedge clock);
        bus_req.write_strobe = 1'b0;
        low_cycles = 0;
        while (bus_rsp.ready !== 1'b1 && low_cycles < WAIT_LIMIT) begin
            low_cycles++;
            @(negedge clock);
        end
        if (bus_rsp.ready !== 1'b1) begin
            timeout_errors++;
            $display("Timed out waiting for ready to return after a write");
        end
        check_count(count_t'(low_cycles), 32'd2, "ready low cycles after a write");
        // Only mapped offsets reach the register copy
        offset = address - BASE_ADDRESS;
        if (offset[1:0] == 2'b00 && offset < bus_addr_t'(4 * REG_COUNT)) begin
            model_regs[int'(offset >> 2)] = (offset == REG_RUN) ? {31'b0, data[0]} : data;
        end
    endtask

    task automatic bus_read(input bus_addr_t address, output bus_data_t data);
        int waited;
        int valid_cycles;
        wait_ready();
        bus_req.address     = address;
        bus_req.read_strobe = 1'b1;
        @(negedge clock);
        bus_req.read_strobe = 1'b0;
        waited = 0;
        while (bus_rsp.read_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        data = bus_rsp.read_data;
        if (bus_rsp.read_valid !== 1'b1) begin
            timeout_errors++;
            $display("Timed out waiting for read_valid after a read");
        end else begin
            // The next strobe waits until this read pulse has ended
            valid_cycles = 0;
            while (bus_rsp.read_valid === 1'b1 && valid_cycles < WAIT_LIMIT) begin
                valid_cycles++;
                @(negedge clock);
            end
            check_count(count_t'(valid_cycles), 32'd1, "read_valid high cycles");
        end
    endtask

    task automatic check_all_regs();
        bus_data_t data;
        for (int i = 0; i < REG_COUNT; i++) begin
            bus_read(BASE_ADDRESS + bus_addr_t'(4 * i), data);
            check_data(data, model_regs[i], $sformatf("register at offset %0d", 4 * i));
        end
    endtask

    // Random offsets past the last threshold register
    task automatic probe_unmapped();
        bus_addr_t address;
        bus_data_t data;
        for (int k = 0; k < 3; k++) begin
            address = BASE_ADDRESS + bus_addr_t'(4 * REG_COUNT)
                      + (bus_addr_t'($random(seed)) & 32'h0000_0ffc);
            bus_write(address, $random(seed));
            bus_read(address, data);
            check_data(data, '0, "unmapped read");
        end
        check_all_regs();
    endtask

    task automatic clear_log();
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            pulse_total[n] = 0;
            gap_min[n]     = '1;
            gap_max[n]     = '0;
        end
    endtask

    task automatic wait_pulses(input enable_vec_t active, input int needed, input count_t period);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < (needed + 2) * (int'(period) + 1) + 20) begin
            @(negedge clock);
            waited++;
            seen = 1'b1;
            for (int n = 0; n < CHANNEL_COUNT; n++) begin
                if (active[n] && pulse_total[n] < needed) begin
                    seen = 1'b0;
                end
            end
        end
        if (!seen) begin
            timeout_errors++;
            $display("Timed out waiting for enable pulses on every active channel");
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clock);
            check_enable(enable_out, '0, what);
        end
    endtask

    task automatic run_row(input row_t row);
        enable_vec_t active;
        count_t      enable_edge;
        int          ref_channel;
        bus_write(BASE_ADDRESS + REG_PERIOD, row.period);
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            // A threshold above the period is never reached
            active[n] = (row.threshold[n] <= row.period);
            bus_write(BASE_ADDRESS + REG_THRESHOLD_0 + bus_addr_t'(4 * n), row.threshold[n]);
        end
        probe_unmapped();
        clear_log();
        if (row.use_run) begin
            bus_write(BASE_ADDRESS + REG_RUN, 32'h0000_00a5);
            check_all_regs();
        end else begin
            gen_enable_in = 1'b1;
        end
        wait_pulses(active, 3, row.period);
        ref_channel = -1;
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            if (!active[n]) begin
                check_count(count_t'(pulse_total[n]), '0, "pulses above the period");
            end else begin
                check_count(gap_min[n], row.period + 1, $sformatf("channel %0d spacing", n));
                check_count(gap_max[n], row.period + 1, $sformatf("channel %0d spacing", n));
                if (ref_channel < 0) begin
                    ref_channel = n;
                end else begin
                    check_count(first_pulse[n] - first_pulse[ref_channel],
                                row.threshold[n] - row.threshold[ref_channel], "channel phase");
                end
            end
        end
        // Stop, then restart from the external enable alone
        if (row.use_run) begin
            bus_write(BASE_ADDRESS + REG_RUN, 32'h0000_00fe);
        end else begin
            gen_enable_in = 1'b0;
        end
        repeat (3) @(negedge clock);
        expect_quiet(int'(row.period) + 4, "enable after stop");
        clear_log();
        gen_enable_in = 1'b1;
        enable_edge   = cycle_count + 1;
        wait_pulses(active, 1, row.period);
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            if (active[n]) begin
                check_count(first_pulse[n] - enable_edge, row.threshold[n] + 1,
                            $sformatf("channel %0d first pulse delay", n));
            end
        end
        gen_enable_in = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    initial begin
        seed           = 32'hd131_653e;
        data_errors    = 0;
        enable_errors  = 0;
        count_errors   = 0;
        timeout_errors = 0;
        cycle_count    = '0;
        reset          = 1'b0;
        gen_enable_in  = 1'b0;
        bus_req        = '0;
        model_regs     = '{default: '0};
        clear_log();
        // Columns are period, thresholds of channels 2 to 0, run bit start flag
        table_rows[0] = {32'd9, 32'd7, 32'd5, 32'd2, 1'b1};
        table_rows[1] = {32'd15, 32'd20, 32'd4, 32'd0, 1'b0};
        table_rows[2] = {32'd6, 32'd3, 32'd1, 32'd6, 1'b1};
        table_rows[3] = {32'd20, 32'd12, 32'd3, 32'd3, 1'b0};
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        check_data(bus_data_t'(bus_rsp.ready), 32'd1, "ready after reset");
        expect_quiet(16, "enable after reset");
        check_all_regs();
        for (int r = 0; r < ROW_COUNT; r++) begin
            run_row(table_rows[r]);
        end
        $display("Errors: data %0d, enable %0d, count %0d, timeout %0d",
                 data_errors, enable_errors, count_errors, timeout_errors);
        if (data_errors + enable_errors + count_errors + timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== design/enable_gen_compare.sv ====
// ======================================================================
// Enable generator compare stage
// One comparator per channel; a match of the running count against
// the channel threshold gives a registered one-cycle enable pulse
// ======================================================================
`timescale 1ns/1ps

module enable_gen_compare (
    input  logic                        clock,
    input  logic                        reset,
    input  enable_gen_pkg::gen_config_t gen_config,
    input  enable_gen_pkg::count_word_t count,
    output enable_gen_pkg::enable_vec_t enable_out
);
    import enable_gen_pkg::*;

    enable_vec_t match;

    // Equality per channel, only while the count is live
    always_comb begin
        match = '0;
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            if (count.running && count.value == gen_config.threshold[n]) begin
                match[n] = 1'b1;
            end
        end
    end

    // A threshold above the period is never reached, so that
    // channel stays quiet
    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_out <= '0;
        end else begin
            enable_out <= match;
        end
    end

endmodule

// ==== design/enable_gen_counter.sv ====
// ======================================================================
// Enable generator count stage
// Sweeps from zero to the period and wraps, while the run bit or
// the external enable is high; cleared otherwise
// ======================================================================
`timescale 1ns/1ps

module enable_gen_counter (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        gen_enable_in,
    input  enable_gen_pkg::gen_config_t gen_config,
    output enable_gen_pkg::count_word_t count
);
    import enable_gen_pkg::*;

    logic   enabled;
    count_t next_value;

    assign enabled = gen_config.run | gen_enable_in;

    // Wrap also covers a period lowered below the current value
    assign next_value = (count.value >= gen_config.period) ? '0 : count.value + 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count.value   <= '0;
            count.running <= 1'b0;
        end else if (enabled) begin
            count.running <= 1'b1;
            // First enabled cycle holds zero, then the sweep starts
            if (count.running) begin
                count.value <= next_value;
            end else begin
                count.value <= '0;
            end
        end else begin
            count.value   <= '0;
            count.running <= 1'b0;
        end
    end

endmodule

// ==== design/enable_gen_pkg.sv ====
// ======================================================================
// Enable generator shared definitions
// Bus and data widths, register map, bus request and response
// structs, configuration and count words, control FSM states
// ======================================================================

package enable_gen_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [31:0] count_t;

    localparam int CHANNEL_COUNT = 3;

    typedef logic [CHANNEL_COUNT-1:0] enable_vec_t;

    // Register map, byte offsets from BASE_ADDRESS
    localparam bus_addr_t BASE_ADDRESS    = 32'h0000_0100;
    localparam bus_addr_t REG_RUN         = 32'h0000_0000;
    localparam bus_addr_t REG_PERIOD      = 32'h0000_0004;
    localparam bus_addr_t REG_THRESHOLD_0 = 32'h0000_0008;
    // Spacing between consecutive threshold registers
    localparam bus_addr_t REG_STRIDE      = 32'h0000_0004;

    // Host to register stage
    typedef struct packed {
        bus_addr_t address;
        bus_data_t write_data;
        logic      write_strobe;
        logic      read_strobe;
    } bus_req_t;

    // Register stage back to host
    typedef struct packed {
        bus_data_t read_data;
        logic      read_valid;
        logic      ready;
    } bus_rsp_t;

    typedef struct packed {
        logic                         run;
        count_t                       period;
        count_t [CHANNEL_COUNT-1:0]   threshold;
    } gen_config_t;

    typedef struct packed {
        count_t value;
        logic   running;
    } count_word_t;

    typedef enum logic {
        CTRL_IDLE,
        CTRL_ACT
    } ctrl_state_t;

endpackage

// ==== design/enable_gen_regs.sv ====
// ======================================================================
// Enable generator register stage
// Strobe bus slave holding run, period and threshold registers.
// Writes are latched, then applied in the act state; reads are
// answered from the same registers one edge after the strobe.
// ======================================================================
`timescale 1ns/1ps

module enable_gen_regs (
    input  logic                        clock,
    input  logic                        reset,
    input  enable_gen_pkg::bus_req_t    bus_req,
    output enable_gen_pkg::bus_rsp_t    bus_rsp,
    output enable_gen_pkg::gen_config_t gen_config
);
    import enable_gen_pkg::*;

    ctrl_state_t state;
    logic        act_done;
    logic        ready_q;
    logic        read_valid_q;
    bus_data_t   read_data_q;
    bus_addr_t   latched_address;
    bus_data_t   latched_data;
    bus_addr_t   write_offset;
    bus_addr_t   read_offset;
    gen_config_t config_q;

    // Readback mux, unmapped offsets give zero
    function automatic bus_data_t read_reg(input bus_addr_t offset, input gen_config_t cfg);
        bus_data_t value;
        value = '0;
        if (offset == REG_RUN) begin
            value[0] = cfg.run;
        end else if (offset == REG_PERIOD) begin
            value = cfg.period;
        end
        for (int n = 0; n < CHANNEL_COUNT; n++) begin
            if (offset == REG_THRESHOLD_0 + REG_STRIDE * bus_addr_t'(n)) begin
                value = cfg.threshold[n];
            end
        end
        return value;
    endfunction

    assign write_offset = latched_address - BASE_ADDRESS;
    assign read_offset  = bus_req.address - BASE_ADDRESS;

    // Shadow copy of a write, taken only while idle
    always_ff @(posedge clock) begin
        if (state == CTRL_IDLE && bus_req.write_strobe) begin
            latched_address <= bus_req.address;
            latched_data    <= bus_req.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= CTRL_IDLE;
            act_done     <= 1'b0;
            ready_q      <= 1'b1;
            read_valid_q <= 1'b0;
            read_data_q  <= '0;
            config_q     <= '0;
        end else begin
            // Read pulse lasts a single cycle
            read_valid_q <= 1'b0;
            read_data_q  <= '0;
            case (state)
                CTRL_IDLE: begin
                    act_done <= 1'b0;
                    if (bus_req.read_strobe) begin
                        read_valid_q <= 1'b1;
                        read_data_q  <= read_reg(read_offset, config_q);
                    end
                    if (bus_req.write_strobe) begin
                        ready_q <= 1'b0;
                        state   <= CTRL_ACT;
                    end
                end
                CTRL_ACT: begin
                    if (!act_done) begin
                        // First act cycle updates the addressed register
                        if (write_offset == REG_RUN) begin
                            config_q.run <= latched_data[0];
                        end else if (write_offset == REG_PERIOD) begin
                            config_q.period <= latched_data;
                        end
                        for (int n = 0; n < CHANNEL_COUNT; n++) begin
                            if (write_offset == REG_THRESHOLD_0 + REG_STRIDE * bus_addr_t'(n)) begin
                                config_q.threshold[n] <= latched_data;
                            end
                        end
                        act_done <= 1'b1;
                    end else begin
                        act_done <= 1'b0;
                        ready_q  <= 1'b1;
                        state    <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    assign bus_rsp.read_data  = read_data_q;
    assign bus_rsp.read_valid = read_valid_q;
    assign bus_rsp.ready      = ready_q;
    assign gen_config         = config_q;

endmodule

// ==== design/enable_gen_top.sv ====
// ======================================================================
// Enable generator top level
// Register stage feeding the count stage and the compare stage;
// brings out the per-channel enable pulses
// ======================================================================
`timescale 1ns/1ps

module enable_gen_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        gen_enable_in,
    input  enable_gen_pkg::bus_req_t    bus_req,
    output enable_gen_pkg::bus_rsp_t    bus_rsp,
    output enable_gen_pkg::enable_vec_t enable_out
);
    import enable_gen_pkg::*;

    gen_config_t gen_config;
    count_word_t count_word;

    enable_gen_regs enable_gen_regs_inst (
        .clock      (clock),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .gen_config (gen_config)
    );

    enable_gen_counter enable_gen_counter_inst (
        .clock         (clock),
        .reset         (reset),
        .gen_enable_in (gen_enable_in),
        .gen_config    (gen_config),
        .count         (count_word)
    );

    // Thresholds come straight from the register stage
    enable_gen_compare enable_gen_compare_inst (
        .clock      (clock),
        .reset      (reset),
        .gen_config (gen_config),
        .count      (count_word),
        .enable_out (enable_out)
    );

endmodule

// ==== enable_gen_top.f ====
design/enable_gen_pkg.sv
design/enable_gen_regs.sv
design/enable_gen_counter.sv
design/enable_gen_compare.sv
design/enable_gen_top.sv
bench/enable_gen_checker.sv
bench/enable_gen_tb.sv
